/* Makefile */
# Verilator build of the timer block testbench

VERILATOR ?= verilator
FLAGS     := --binary --timing -Isrc
TOP       := timerBlockTb
FILELIST  := compile.f

BUILD_DIR := build
SIM       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := $(wildcard src/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulator gives pass or fail
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+src
src/periphPkg.sv
src/timer16.sv
src/periphBusDecode.sv
src/intrCollector.sv
src/timerBlock.sv
verification/timerBlockTb.sv

/* src/intrCollector.sv */
`timescale 1ns/1ps
`include "timerMacros.svh"

module intrCollector (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    wr,      // Write strobe for this unit
  input  periphPkg::regAddrT      regAddr,
  input  periphPkg::wordT         wrData,
  input  logic [`TIMER_COUNT-1:0] ovf,     // Overflow pulses from timers
  output periphPkg::wordT         rdData,
  output logic                    irq      // Registered interrupt level
);

  // Register map
  localparam periphPkg::regAddrT addrPending = 2'd0;
  localparam periphPkg::regAddrT addrMask    = 2'd1;

  logic [`TIMER_COUNT-1:0] pending;
  logic [`TIMER_COUNT-1:0] mask;
  logic [`TIMER_COUNT-1:0] clrBits; // Write-one-to-clear request

  assign clrBits = (wr && regAddr == addrPending) ? wrData[`TIMER_COUNT-1:0] : '0;

  //////////////////////////////////////////////////
  // Pending and mask
  //////////////////////////////////////////////////

  // New overflow wins over a same-cycle clear
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clrBits) | ovf;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mask <= '0;
    end else if (wr && regAddr == addrMask) begin
      mask <= wrData[`TIMER_COUNT-1:0];
    end
  end

  // One cycle behind pending and mask
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      irq <= 1'b0;
    end else begin
      irq <= |(pending & mask);
    end
  end

  //////////////////////////////////////////////////
  // Read word
  //////////////////////////////////////////////////

  always_comb begin
    case (regAddr)
      addrPending: rdData = periphPkg::wordT'(pending); // Zero extended
      addrMask:    rdData = periphPkg::wordT'(mask);
      default:     rdData = '0;
    endcase
  end

endmodule

/* src/periphBusDecode.sv */
`timescale 1ns/1ps
`include "timerMacros.svh"

module periphBusDecode (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    busEn,   // Request strobe
  input  logic                    busWr,   // 1 write, 0 read
  input  logic [`ADDR_W-1:0]      busAddr,
  output periphPkg::regAddrT      regAddr, // To every unit
  output logic [`TIMER_COUNT-1:0] timerWr, // One strobe per timer
  output logic                    intrWr,
  input  periphPkg::wordT         timerRdData [`TIMER_COUNT],
  input  periphPkg::wordT         intrRdData,
  output periphPkg::wordT         rdData,
  output logic                    rdValid  // One cycle after read strobe
);

  localparam int unitW = `ADDR_W - 2;

  logic [unitW-1:0] unit;  // Upper address bits
  logic             wrStb;
  logic             rdStb;
  periphPkg::wordT  rdSel; // Selected unit word before the flop

  assign unit    = busAddr[`ADDR_W-1:2];
  assign regAddr = busAddr[1:0];
  assign wrStb   = busEn & busWr;
  assign rdStb   = busEn & ~busWr;

  //////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      timerWr[i] = wrStb && (unit == unitW'(i));
    end
  end

  assign intrWr = wrStb && (unit == unitW'(`UNIT_INTR));

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  // Unused units fall through to zero
  always_comb begin
    rdSel = '0;
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      if (unit == unitW'(i)) rdSel = timerRdData[i];
    end
    if (unit == unitW'(`UNIT_INTR)) rdSel = intrRdData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdValid <= 1'b0;
      rdData  <= '0;
    end else begin
      rdValid <= rdStb;
      if (rdStb) rdData <= rdSel; // Hold between reads
    end
  end

endmodule

/* src/periphPkg.sv */
`include "timerMacros.svh"

package periphPkg;

  //////////////////////////////////////////////////
  // Bus types
  //////////////////////////////////////////////////

  // One data word on the register bus
  typedef logic [`DATA_W-1:0] wordT;

  // Register select inside one unit
  typedef logic [1:0] regAddrT;

  //////////////////////////////////////////////////
  // Timer control word
  //////////////////////////////////////////////////

  // Field layout of the control register
  typedef struct packed {
    logic [7:0]       rsvdHi;   // Reads as zero
    logic [`PS_W-1:0] prescale; // Bits 7..4
    logic [2:0]       rsvdLo;   // Reads as zero
    logic             enable;   // Bit 0
  } timerCtlFieldsT;

  // Same word seen raw from the bus or as fields
  typedef union packed {
    wordT           raw;
    timerCtlFieldsT fields;
  } timerCtlU;

endpackage

/* src/timer16.sv */
`timescale 1ns/1ps
`include "timerMacros.svh"

module timer16 (
  input  logic               clk,
  input  logic               rstN,
  input  logic               wr,      // Write strobe for this timer only
  input  periphPkg::regAddrT regAddr, // Local register select
  input  periphPkg::wordT    wrData,
  output periphPkg::wordT    rdData,  // Combinational read word
  output logic               ovf      // One-cycle overflow pulse
);

  // Register map
  localparam periphPkg::regAddrT addrValue = 2'd0;
  localparam periphPkg::regAddrT addrCtl   = 2'd1;
  // Max count answers at 2 and 3

  //////////////////////////////////////////////////
  // Registers and internal signals
  //////////////////////////////////////////////////

  periphPkg::wordT     value;      // Visible count
  periphPkg::wordT     maxCnt;     // Wrap point
  periphPkg::timerCtlU ctl;        // Enable and prescale
  periphPkg::timerCtlU ctlWrWord;  // Bus word with reserved bits cleared
  logic [`PS_W-1:0]    psCnt;      // Hidden prescale counter

  logic tick;      // Prescale period done
  logic atMax;     // Value sits on max count
  logic countEn;   // Advance value this cycle
  logic valueWr;
  logic ctlWr;
  logic maxWr;

  //////////////////////////////////////////////////
  // Decode and compare
  //////////////////////////////////////////////////

  assign tick    = (psCnt == ctl.fields.prescale);
  assign atMax   = (value == maxCnt);
  assign countEn = tick & ctl.fields.enable; // Only counts when enabled

  assign valueWr = wr & (regAddr == addrValue);
  assign ctlWr   = wr & (regAddr == addrCtl);
  assign maxWr   = wr & regAddr[1]; // 2 or 3

  // Control write keeps only prescale and enable
  always_comb begin
    ctlWrWord.raw           = wrData; // Load through raw view
    ctlWrWord.fields.rsvdHi = '0;
    ctlWrWord.fields.rsvdLo = '0;
  end

  //////////////////////////////////////////////////
  // Prescaler
  //////////////////////////////////////////////////

  // Free running, cleared on tick or any write to this timer
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      psCnt <= '0;
    end else if (tick || wr) begin
      psCnt <= '0;
    end else begin
      psCnt <= psCnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Value, control and max registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      value <= '0;
    end else if (valueWr) begin
      value <= wrData;               // Bus load beats counting
    end else if (countEn) begin
      value <= atMax ? '0 : value + 1'b1; // Roll over after max
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctl <= '0;
    end else if (ctlWr) begin
      ctl <= ctlWrWord;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      maxCnt <= '0;
    end else if (maxWr) begin
      maxCnt <= wrData;
    end
  end

  // Overflow pulse one cycle after the wrapping tick
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ovf <= 1'b0;
    end else begin
      ovf <= countEn & atMax;
    end
  end

  //////////////////////////////////////////////////
  // Read word
  //////////////////////////////////////////////////

  always_comb begin
    case (regAddr)
      addrValue: rdData = value;
      addrCtl:   rdData = ctl.fields; // Field view, reserved bits zero
      default:   rdData = maxCnt;
    endcase
  end

endmodule

/* src/timerBlock.sv */
`timescale 1ns/1ps
`include "timerMacros.svh"

module timerBlock (
  input  logic               clk,
  input  logic               rstN,
  input  logic               busEn,
  input  logic               busWr,
  input  logic [`ADDR_W-1:0] busAddr,
  input  periphPkg::wordT    wrData,
  output periphPkg::wordT    rdData,
  output logic               rdValid,
  output logic               irq
);

  //////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////

  periphPkg::regAddrT      regAddr;                    // Shared register select
  logic [`TIMER_COUNT-1:0] timerWr;
  logic                    intrWr;
  periphPkg::wordT         timerRdData [`TIMER_COUNT]; // Per-timer read words
  periphPkg::wordT         intrRdData;
  logic [`TIMER_COUNT-1:0] ovf;                        // Timer to collector

  // Address split and read mux
  periphBusDecode busDecode_inst (
    .clk         (clk),
    .rstN        (rstN),
    .busEn       (busEn),
    .busWr       (busWr),
    .busAddr     (busAddr),
    .regAddr     (regAddr),
    .timerWr     (timerWr),
    .intrWr      (intrWr),
    .timerRdData (timerRdData),
    .intrRdData  (intrRdData),
    .rdData      (rdData),
    .rdValid     (rdValid)
  );

  // One timer per unit slot
  for (genvar i = 0; i < `TIMER_COUNT; i++) begin : genTimer
    timer16 timer_inst (
      .clk     (clk),
      .rstN    (rstN),
      .wr      (timerWr[i]),
      .regAddr (regAddr),
      .wrData  (wrData),     // Bus data straight to every unit
      .rdData  (timerRdData[i]),
      .ovf     (ovf[i])
    );
  end

  intrCollector intrCollector_inst (
    .clk     (clk),
    .rstN    (rstN),
    .wr      (intrWr),
    .regAddr (regAddr),
    .wrData  (wrData),
    .ovf     (ovf),
    .rdData  (intrRdData),
    .irq     (irq)
  );

endmodule

/* src/timerMacros.svh */
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

`define DATA_W 16 // Bus and register word
`define ADDR_W 4  // Unit in [3:2], register in [1:0]

//////////////////////////////////////////////////
// Timer setup
//////////////////////////////////////////////////

// Prescale field width in the control word
`define PS_W 4

// Timers sit at units 0 .. TIMER_COUNT-1 (1 to 3 allowed)
`define TIMER_COUNT 2

// Interrupt collector unit
`define UNIT_INTR 3

`endif

/* verification/timerBlockTb.sv */
`timescale 1ns/1ps
`include "timerMacros.svh"

module timerBlockTb;

  localparam int timeoutCycles = 12000; // Well above the directed plus random run
  localparam int randomCycles  = 4000;
  localparam int lastTimer     = `TIMER_COUNT - 1;

  logic               clk;
  logic               rstN;
  logic               busEn;
  logic               busWr;
  logic [`ADDR_W-1:0] busAddr;
  periphPkg::wordT    wrData;
  periphPkg::wordT    rdData;
  logic               rdValid;
  logic               irq;

  timerBlock timerBlock_inst (
    .clk     (clk),
    .rstN    (rstN),
    .busEn   (busEn),
    .busWr   (busWr),
    .busAddr (busAddr),
    .wrData  (wrData),
    .rdData  (rdData),
    .rdValid (rdValid),
    .irq     (irq)
  );

  always #20 clk = ~clk; // 40 ns period

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////

  periphPkg::wordT         mValue [`TIMER_COUNT];
  periphPkg::wordT         mMax   [`TIMER_COUNT];
  logic [`PS_W-1:0]        mPs    [`TIMER_COUNT];
  logic [`PS_W-1:0]        mPsCnt [`TIMER_COUNT];
  logic                    mEn    [`TIMER_COUNT];
  logic [`TIMER_COUNT-1:0] mOvf;
  logic [`TIMER_COUNT-1:0] mPending;
  logic [`TIMER_COUNT-1:0] mMask;
  periphPkg::wordT         expRdData;
  logic                    expRdValid;
  logic                    expIrq;
  logic [31:0]             lfsrState;
  int                      cycleCount;

  // Galois LFSR stepped once per bit
  function automatic logic randBit();
    logic lsb;
    lsb = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) lfsrState = lfsrState ^ 32'h8020_0003;
    return lfsrState[0];
  endfunction

  function automatic periphPkg::wordT randBits(input int n);
    periphPkg::wordT r;
    r = '0;
    for (int k = 0; k < n; k++) r = {r[14:0], randBit()};
    return r;
  endfunction

  function automatic logic [`ADDR_W-1:0] addrOf(input int unit, input int regSel);
    return {unit[1:0], regSel[1:0]};
  endfunction

  // Register word as the bus would see it right now
  function automatic periphPkg::wordT readWordOf(input logic [1:0] unit,
                                                  input periphPkg::regAddrT regSel);
    periphPkg::wordT w;
    w = '0;
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      if (unit == 2'(i)) begin
        if (regSel == 2'd0) w = mValue[i];
        else if (regSel == 2'd1) w = {8'h00, mPs[i], 3'b000, mEn[i]}; // Only live fields
        else w = mMax[i];
      end
    end
    if (unit == 2'(`UNIT_INTR)) begin
      if (regSel == 2'd0) w = periphPkg::wordT'(mPending);
      else if (regSel == 2'd1) w = periphPkg::wordT'(mMask);
    end
    return w;
  endfunction

  // Advance the model by one clock edge with the given bus inputs
  task automatic stepModel(input logic en, input logic wr, input logic [`ADDR_W-1:0] addr,
                           input periphPkg::wordT data);
    logic [1:0]              unit;
    periphPkg::regAddrT      regSel;
    logic                    tWr;
    logic                    tick;
    logic                    cntEn;
    logic [`TIMER_COUNT-1:0] nextOvf;
    logic [`TIMER_COUNT-1:0] clr;
    periphPkg::wordT         rdWord;
    unit   = addr[3:2];
    regSel = addr[1:0];
    rdWord = readWordOf(unit, regSel); // Sampled before any update
    clr = (en && wr && unit == 2'(`UNIT_INTR) && regSel == 2'd0) ?
          data[`TIMER_COUNT-1:0] : '0;
    expIrq   = |(mPending & mMask);
    mPending = (mPending & ~clr) | mOvf; // Set beats clear
    if (en && wr && unit == 2'(`UNIT_INTR) && regSel == 2'd1) mMask = data[`TIMER_COUNT-1:0];
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      tWr        = en && wr && unit == 2'(i);
      tick       = (mPsCnt[i] == mPs[i]);
      cntEn      = tick && mEn[i];
      nextOvf[i] = cntEn && (mValue[i] == mMax[i]);
      if (tWr && regSel == 2'd0) mValue[i] = data;
      else if (cntEn) mValue[i] = (mValue[i] == mMax[i]) ? 16'd0 : mValue[i] + 16'd1;
      if (tWr && regSel == 2'd1) begin
        mPs[i] = data[4 +: `PS_W];
        mEn[i] = data[0];
      end
      if (tWr && regSel[1]) mMax[i] = data;
      mPsCnt[i] = (tick || tWr) ? '0 : mPsCnt[i] + 1'b1;
    end
    mOvf       = nextOvf;
    expRdValid = en && !wr;
    if (en && !wr) expRdData = rdWord; // Read data holds between reads
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic stopOnError();
    $display("TESTS FAILED");
    $fatal(1, "Output mismatch, simulation stopped");
  endtask

  task automatic compareWord(input string name, input periphPkg::wordT exp,
                             input periphPkg::wordT act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      stopOnError();
    end
  endtask

  task automatic compareBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, exp, act);
      stopOnError();
    end
  endtask

  // Outputs settle well before the falling edge
  task automatic checkOutputs();
    compareBit("rdValid", expRdValid, rdValid);
    compareBit("irq", expIrq, irq);
    if (expRdValid) compareWord("rdData", expRdData, rdData);
  endtask

  //////////////////////////////////////////////////
  // Bus driving
  //////////////////////////////////////////////////

  task automatic driveCycle(input logic en, input logic wr, input logic [`ADDR_W-1:0] addr,
                            input periphPkg::wordT data);
    @(negedge clk);
    checkOutputs();
    busEn   = en;
    busWr   = wr;
    busAddr = addr;
    wrData  = data;
    stepModel(en, wr, addr, data);
  endtask

  task automatic writeReg(input logic [`ADDR_W-1:0] addr, input periphPkg::wordT data);
    driveCycle(1'b1, 1'b1, addr, data);
  endtask

  task automatic readReg(input logic [`ADDR_W-1:0] addr);
    driveCycle(1'b1, 1'b0, addr, 16'h0000);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) driveCycle(1'b0, 1'b0, '0, 16'h0000);
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("TESTS FAILED");
      $fatal(1, "Timeout: the test did not finish within %0d cycles", timeoutCycles);
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic               en;
    logic               wr;
    logic [`ADDR_W-1:0] addr;
    periphPkg::wordT    data;
    clk = 1'b0;
    rstN = 1'b0;
    busEn = 1'b0;
    busWr = 1'b0;
    busAddr = '0;
    wrData = '0;
    cycleCount = 0;
    lfsrState = 32'd32; // Seed
    for (int i = 0; i < `TIMER_COUNT; i++) begin
      mValue[i] = '0;
      mMax[i]   = '0;
      mPs[i]    = '0;
      mPsCnt[i] = '0;
      mEn[i]    = 1'b0;
    end
    mOvf = '0;
    mPending = '0;
    mMask = '0;
    expRdData = '0;
    expRdValid = 1'b0;
    expIrq = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Register access and readback
    for (int t = 0; t < `TIMER_COUNT; t++) begin
      writeReg(addrOf(t, 0), periphPkg::wordT'(16'h1234 + t));
      writeReg(addrOf(t, 1), 16'hFF3E); // Prescale 3 with reserved bits set and enable low
      writeReg(addrOf(t, 2), 16'hBEEF);
      for (int r = 0; r < 4; r++) readReg(addrOf(t, r));
    end
    writeReg(addrOf(2, 1), 16'hFFFF); // Unit 2 unused with two timers
    readReg(addrOf(2, 1));
    writeReg(addrOf(`UNIT_INTR, 1), 16'hFFFF);
    readReg(addrOf(`UNIT_INTR, 1));
    readReg(addrOf(`UNIT_INTR, 2));
    writeReg(addrOf(`UNIT_INTR, 1), 16'h0000);

    // Prescaled counting with P = 3
    writeReg(addrOf(0, 0), 16'h0000);
    writeReg(addrOf(0, 2), 16'h0100);
    writeReg(addrOf(0, 1), 16'h0031);
    for (int k = 0; k < 8; k++) begin
      idleCycles(k + 1);
      readReg(addrOf(0, 0));
    end
    writeReg(addrOf(0, 1), 16'h0000);

    // Wrap at max 3 on the last timer
    writeReg(addrOf(lastTimer, 0), 16'h0000);
    writeReg(addrOf(lastTimer, 2), 16'h0003);
    writeReg(addrOf(lastTimer, 1), 16'h0001);
    for (int k = 0; k < 6; k++) readReg(addrOf(lastTimer, 0));
    idleCycles(4);
    readReg(addrOf(`UNIT_INTR, 0));

    // Masking and clearing, then a clear against a new overflow
    idleCycles(4); // irq held low by the zero mask
    writeReg(addrOf(`UNIT_INTR, 1), periphPkg::wordT'(1 << lastTimer));
    idleCycles(4);
    writeReg(addrOf(lastTimer, 1), 16'h0000);
    idleCycles(3);
    writeReg(addrOf(`UNIT_INTR, 0), 16'hFFFF);
    idleCycles(3);
    readReg(addrOf(`UNIT_INTR, 0));
    writeReg(addrOf(lastTimer, 1), 16'h0001);
    repeat (12) writeReg(addrOf(`UNIT_INTR, 0), 16'hFFFF); // Hits ovf cycles too
    readReg(addrOf(`UNIT_INTR, 0));
    writeReg(addrOf(lastTimer, 1), 16'h0000);
    idleCycles(3);

    // Random traffic with small max and prescale
    for (int c = 0; c < randomCycles; c++) begin
      en   = randBit();
      wr   = randBit();
      data = randBits(`ADDR_W);
      addr = data[`ADDR_W-1:0];
      data = randBits(16);
      if (addr[3:2] != 2'(`UNIT_INTR)) begin
        if (addr[1:0] == 2'd1) data = data & 16'hFF3F; // Prescale 0 to 3
        else data = {13'd0, data[2:0]};
      end
      driveCycle(en, wr, addr, data);
    end
    idleCycles(2);

    $display("TESTS PASSED");
    $finish;
  end

endmodule
